/* Makefile */
TOP = tb_vmicro16
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/vmicro16_alu.sv */
/* vmicro16 ALU
   combinational bitwise, shift, unsigned add/sub and pass-through operations */
`timescale 1ns/1ps
`default_nettype none

module vmicro16_alu
    import vmicro16_bus_pkg::*,
           vmicro16_isa_pkg::*;
(
    input  wire alu_op_t op,
    // rd value
    input  wire word_t   a,
    // ra value or immediate
    input  wire word_t   b,
    output word_t        c
);

    always_comb begin
        case (op)
            // moves and load/store base just forward b
            ALU_MOV,
            ALU_MOVI,
            ALU_LW,
            ALU_SW:    c = b;

            ALU_OR:    c = a | b;
            ALU_XOR:   c = a ^ b;
            ALU_AND:   c = a & b;
            ALU_NOT:   c = ~b;
            ALU_LSHFT: c = a << b;
            ALU_RSHFT: c = a >> b;

            // wraps modulo 2^16
            ALU_ADD:   c = a + b;
            ALU_SUB:   c = a - b;

            // nop, bad
            default:   c = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/vmicro16_bram.sv */
/* vmicro16 block RAM
   synchronous single-port memory, a write takes the port for that cycle */
`timescale 1ns/1ps
`default_nettype none

module vmicro16_bram
    import vmicro16_bus_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  wire logic      clk,
    input  wire mem_addr_t addr,
    input  wire word_t     wdata,
    input  wire logic      we,
    output word_t          rdata
);

    word_t mem [DEPTH];

    // write has priority, rdata holds its last value meanwhile
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/vmicro16_bus_pkg.sv */
/* vmicro16 memory and bus traffic
   word, memory address and memory unit state types */
`default_nettype none

`include "vmicro16_defs.svh"

package vmicro16_bus_pkg;

    typedef logic [`VM_WORD_WIDTH-1:0] word_t;

    // instruction and scratch memories share one depth
    typedef logic [$clog2(`VM_INSTR_DEPTH)-1:0] mem_addr_t;

    // one-cycle scratch path and the APB setup and access phases
    typedef enum logic [1:0] {
        MMU_IDLE,
        MMU_SCRATCH,
        MMU_SETUP,
        MMU_ACCESS
    } mmu_state_t;

endpackage

`default_nettype wire

/* rtl/vmicro16_core.sv */
/* vmicro16 core top level
   multicycle fetch/execute FSM with program-load port and APB master */
`timescale 1ns/1ps
`default_nettype none

`include "vmicro16_defs.svh"

module vmicro16_core
    import vmicro16_bus_pkg::*,
           vmicro16_isa_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      run,
    input  wire logic      prog_we,
    input  wire mem_addr_t prog_addr,
    input  wire word_t     prog_data,
    output logic           halted,
    output word_t          paddr,
    output logic           pwrite,
    output logic           psel,
    output logic           penable,
    output word_t          pwdata,
    input  wire word_t     prdata,
    input  wire logic      pready
);

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_R1, S_R2, S_ME, S_WB, S_HALTED
    } core_state_t;

    core_state_t state_q;
    mem_addr_t   pc_q;
    word_t       instr_q;
    word_t       instr_rdata;
    word_t       rd_val_q;
    word_t       load_q;
    word_t       mem_addr_q;
    logic        mem_req_q;
    logic        mem_done;
    word_t       mem_rdata;

    reg_sel_t    rd;
    reg_sel_t    ra;
    logic [7:0]  imm8;
    logic [4:0]  simm5;
    alu_op_t     alu_op;
    logic        has_imm8;
    logic        has_we;
    logic        has_mem;
    logic        has_mem_we;
    logic        halt;

    word_t       rd1;
    word_t       rd2;
    word_t       opb;
    word_t       alu_c;
    logic        reg_we;
    logic        load_port;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= S_IDLE;
            pc_q      <= '0;
            mem_req_q <= 1'b0;
        end else begin
            mem_req_q <= 1'b0;
            case (state_q)
                // never start while a program word is still landing
                S_IDLE:   if (run && !prog_we) state_q <= S_FETCH;
                S_FETCH: begin
                    pc_q    <= pc_q + 1'b1;
                    state_q <= S_R1;
                end
                S_R1:     state_q <= S_R2;
                S_R2: begin
                    if (halt) begin
                        state_q <= S_HALTED;
                    end else if (has_mem) begin
                        mem_req_q <= 1'b1;
                        state_q   <= S_ME;
                    end else begin
                        state_q <= S_FETCH;
                    end
                end
                S_ME:     if (mem_done) state_q <= S_WB;
                S_WB:     state_q <= S_FETCH;
                S_HALTED: state_q <= S_HALTED;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    // instruction and operand latches
    always_ff @(posedge clk) begin
        if (state_q == S_FETCH) instr_q <= instr_rdata;
        if (state_q == S_R1) rd_val_q <= rd1;
        if (state_q == S_R2) mem_addr_q <= alu_c + word_t'(simm5);
        if (state_q == S_ME && mem_done) load_q <= mem_rdata;
    end

    assign load_port = (state_q == S_IDLE) && prog_we;
    assign opb       = has_imm8 ? word_t'(imm8) : rd2;
    assign halted    = (state_q == S_HALTED);

    // ALU results retire in R2, loads in WB
    assign reg_we = has_we && (((state_q == S_R2) && !has_mem) || (state_q == S_WB));

    vmicro16_bram #(
        .DEPTH (`VM_INSTR_DEPTH)
    ) instr_mem (
        .clk   (clk),
        .addr  (load_port ? prog_addr : pc_q),
        .wdata (prog_data),
        .we    (load_port),
        .rdata (instr_rdata)
    );

    vmicro16_dec dec (
        .instr      (instr_q),
        .opcode     (),
        .rd         (rd),
        .ra         (ra),
        .imm8       (imm8),
        .simm5      (simm5),
        .alu_op     (alu_op),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we),
        .halt       (halt)
    );

    vmicro16_regs regs (
        .clk   (clk),
        .reset (reset),
        .rs1   (rd),
        .rs2   (ra),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (reg_we),
        .ws    (rd),
        .wd    ((state_q == S_WB) ? load_q : alu_c)
    );

    vmicro16_alu alu (
        .op (alu_op),
        .a  (rd_val_q),
        .b  (opb),
        .c  (alu_c)
    );

    vmicro16_mmu mmu (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req_q),
        .addr    (mem_addr_q),
        .wdata   (rd_val_q),
        .we      (has_mem_we),
        .done    (mem_done),
        .rdata   (mem_rdata),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state_q inside {S_IDLE, S_FETCH, S_R1, S_R2, S_ME, S_WB, S_HALTED});

endmodule

`default_nettype wire

/* rtl/vmicro16_dec.sv */
/* vmicro16 instruction decoder
   splits out the fields and derives the ALU operation and control flags */
`timescale 1ns/1ps
`default_nettype none

module vmicro16_dec
    import vmicro16_bus_pkg::*,
           vmicro16_isa_pkg::*;
(
    input  wire word_t instr,
    output opcode_t    opcode,
    output reg_sel_t   rd,
    output reg_sel_t   ra,
    output logic [7:0] imm8,
    output logic [4:0] simm5,
    output alu_op_t    alu_op,
    output logic       has_imm8,
    output logic       has_we,
    output logic       has_mem,
    output logic       has_mem_we,
    output logic       halt
);

    assign opcode = opcode_t'(instr[15:11]);
    assign rd     = instr[10:8];
    assign ra     = instr[7:5];
    assign imm8   = instr[7:0];
    assign simm5  = instr[4:0];

    assign halt   = (opcode == OP_HALT);

    always_comb begin
        alu_op = ALU_BAD;
        case (opcode)
            OP_NOP, OP_HALT: alu_op = ALU_NOP;
            OP_MOV:          alu_op = ALU_MOV;
            OP_MOVI:         alu_op = ALU_MOVI;
            OP_LW:           alu_op = ALU_LW;
            OP_SW:           alu_op = ALU_SW;
            // function selector sits in simm5
            OP_BIT: begin
                case (bit_func_t'(simm5))
                    BIT_OR:    alu_op = ALU_OR;
                    BIT_XOR:   alu_op = ALU_XOR;
                    BIT_AND:   alu_op = ALU_AND;
                    BIT_NOT:   alu_op = ALU_NOT;
                    BIT_LSHFT: alu_op = ALU_LSHFT;
                    BIT_RSHFT: alu_op = ALU_RSHFT;
                    default:   alu_op = ALU_BAD;
                endcase
            end
            OP_ARITH_U: begin
                case (arith_func_t'(simm5))
                    ARITH_ADD: alu_op = ALU_ADD;
                    ARITH_SUB: alu_op = ALU_SUB;
                    default:   alu_op = ALU_BAD;
                endcase
            end
            default:         alu_op = ALU_BAD;
        endcase
    end

    // a bad selector must not clobber rd
    always_comb begin
        case (opcode)
            OP_MOV, OP_MOVI, OP_LW, OP_BIT, OP_ARITH_U: has_we = (alu_op != ALU_BAD);
            default:                                   has_we = 1'b0;
        endcase
    end

    assign has_imm8   = (opcode == OP_MOVI);
    assign has_mem    = (opcode == OP_LW) || (opcode == OP_SW);
    assign has_mem_we = (opcode == OP_SW);

endmodule

`default_nettype wire

/* rtl/vmicro16_defs.svh */
/* vmicro16 build parameters
   word width, register count, memory depths and the scratch address window */
`ifndef VMICRO16_DEFS_SVH
`define VMICRO16_DEFS_SVH

// data and instruction word
`define VM_WORD_WIDTH       16

// general purpose registers
`define VM_REG_COUNT        8

// instruction memory, in words
`define VM_INSTR_DEPTH      64

// scratch memory, in words
`define VM_SCRATCH_DEPTH    64

// scratch window starts at 0; everything above goes out over APB
`define VM_SCRATCH_LAST     'h3F

`endif

/* rtl/vmicro16_isa_pkg.sv */
/* vmicro16 instruction set
   opcode, function selector, ALU operation and register index types */
`default_nettype none

`include "vmicro16_defs.svh"

package vmicro16_isa_pkg;

    // bits 15..11 of every instruction
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_MOV     = 5'h01,
        OP_MOVI    = 5'h02,
        OP_LW      = 5'h03,
        OP_SW      = 5'h04,
        OP_BIT     = 5'h05,
        OP_ARITH_U = 5'h06,
        OP_HALT    = 5'h1F
    } opcode_t;

    // simm5 field of a BIT instruction
    typedef enum logic [4:0] {
        BIT_OR    = 5'h00,
        BIT_XOR   = 5'h01,
        BIT_AND   = 5'h02,
        BIT_NOT   = 5'h03,
        BIT_LSHFT = 5'h04,
        BIT_RSHFT = 5'h05
    } bit_func_t;

    // simm5 field of an ARITH_U instruction
    typedef enum logic [4:0] {
        ARITH_ADD = 5'h00,
        ARITH_SUB = 5'h01
    } arith_func_t;

    // internal ALU operations may be renumbered freely
    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_MOV,
        ALU_MOVI,
        ALU_LW,
        ALU_SW,
        ALU_OR,
        ALU_XOR,
        ALU_AND,
        ALU_NOT,
        ALU_LSHFT,
        ALU_RSHFT,
        ALU_ADD,
        ALU_SUB,
        ALU_BAD
    } alu_op_t;

    typedef logic [$clog2(`VM_REG_COUNT)-1:0] reg_sel_t;

endpackage

`default_nettype wire

/* rtl/vmicro16_mmu.sv */
/* vmicro16 memory unit
   sends low addresses to the scratch RAM and the rest to the APB master */
`timescale 1ns/1ps
`default_nettype none

`include "vmicro16_defs.svh"

module vmicro16_mmu
    import vmicro16_bus_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  req,
    input  wire word_t addr,
    input  wire word_t wdata,
    input  wire logic  we,
    output logic       done,
    output word_t      rdata,
    output word_t      paddr,
    output logic       pwrite,
    output logic       psel,
    output logic       penable,
    output word_t      pwdata,
    input  wire word_t prdata,
    input  wire logic  pready
);

    mmu_state_t state_q;
    logic       in_scratch;
    logic       apb_done_q;
    word_t      apb_rdata_q;
    word_t      scratch_rdata;

    assign in_scratch = (addr <= word_t'(`VM_SCRATCH_LAST));

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= MMU_IDLE;
            psel       <= 1'b0;
            penable    <= 1'b0;
            apb_done_q <= 1'b0;
        end else begin
            apb_done_q <= 1'b0;
            case (state_q)
                MMU_IDLE: begin
                    if (req && in_scratch) begin
                        state_q <= MMU_SCRATCH;
                    end else if (req) begin
                        psel    <= 1'b1;
                        state_q <= MMU_SETUP;
                    end
                end
                // bram answers one cycle after req
                MMU_SCRATCH: state_q <= MMU_IDLE;
                MMU_SETUP: begin
                    penable <= 1'b1;
                    state_q <= MMU_ACCESS;
                end
                MMU_ACCESS: begin
                    // slave back-pressure holds us here
                    if (pready) begin
                        psel       <= 1'b0;
                        penable    <= 1'b0;
                        apb_done_q <= 1'b1;
                        state_q    <= MMU_IDLE;
                    end
                end
                default: state_q <= MMU_IDLE;
            endcase
        end
    end

    // APB payload held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (state_q == MMU_IDLE && req && !in_scratch) begin
            paddr  <= addr;
            pwrite <= we;
            pwdata <= wdata;
        end
        if (state_q == MMU_ACCESS && pready) begin
            apb_rdata_q <= prdata;
        end
    end

    assign done  = (state_q == MMU_SCRATCH) || apb_done_q;
    assign rdata = (state_q == MMU_SCRATCH) ? scratch_rdata : apb_rdata_q;

    vmicro16_bram #(
        .DEPTH (`VM_SCRATCH_DEPTH)
    ) scratch_mem (
        .clk   (clk),
        .addr  (mem_addr_t'(addr)),
        .wdata (wdata),
        .we    (req && in_scratch && we && state_q == MMU_IDLE),
        .rdata (scratch_rdata)
    );

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

    // core keeps one access in flight
    a_req_only_idle: assert property (@(posedge clk) disable iff (reset)
        req |-> state_q == MMU_IDLE);

endmodule

`default_nettype wire

/* rtl/vmicro16_regs.sv */
/* vmicro16 register file
   two combinational read ports, one synchronous write port */
`timescale 1ns/1ps
`default_nettype none

`include "vmicro16_defs.svh"

module vmicro16_regs
    import vmicro16_bus_pkg::*,
           vmicro16_isa_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire reg_sel_t rs1,
    input  wire reg_sel_t rs2,
    output word_t         rd1,
    output word_t         rd2,
    input  wire logic     we,
    input  wire reg_sel_t ws,
    input  wire word_t    wd
);

    word_t regs [`VM_REG_COUNT];

    // each register comes out of reset holding its own index
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VM_REG_COUNT; i++) begin
                regs[i] <= word_t'(i);
            end
        end else if (we) begin
            regs[ws] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/vmicro16_isa_pkg.sv
rtl/vmicro16_bus_pkg.sv
rtl/vmicro16_bram.sv
rtl/vmicro16_regs.sv
rtl/vmicro16_dec.sv
rtl/vmicro16_alu.sv
rtl/vmicro16_mmu.sv
rtl/vmicro16_core.sv
tb/tb_vmicro16.sv

/* tb/tb_vmicro16.sv */
/* vmicro16 testbench
   loads a program from file, models the APB slave and checks every APB write */
`timescale 1ns/1ps
`default_nettype none

module tb_vmicro16
    import vmicro16_bus_pkg::*;
();

    // write index at which each program section ends
    localparam int WB_END      = 3;
    localparam int ALU_END     = 12;
    localparam int SCRATCH_END = 13;

    // peripheral loads in the program
    localparam int APB_READS   = 2;

    logic      clk       = 1'b0;
    logic      reset     = 1'b1;
    logic      run       = 1'b0;
    logic      prog_we   = 1'b0;
    mem_addr_t prog_addr = '0;
    word_t     prog_data = '0;
    word_t     prdata    = '0;
    logic      pready    = 1'b0;
    logic      halted;
    word_t     paddr;
    logic      pwrite;
    logic      psel;
    logic      penable;
    word_t     pwdata;

    logic [15:0] vec [128];
    word_t       exp_addr [64];
    word_t       exp_data [64];
    word_t       got_addr [64];
    word_t       got_data [64];
    word_t       model_mem [256];
    int          prog_len;
    int          exp_writes;
    int          write_count     = 0;
    int          read_count      = 0;
    int          pass_count      = 0;
    int          fail_count      = 0;
    int          watchdog_cycles = 0;
    int          wait_left       = 0;
    integer      seed            = 32'hc914;

    always #4 clk = ~clk;

    vmicro16_core i_vmicro16_core (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    task automatic check_value(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d problem(s)", name, fail_count - fails_before);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= mem_addr_t'(i);
            prog_data <= vec[i + 1];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // stops early once the core halts, missing writes then show as mismatches
    task automatic wait_for_writes(input int count);
        while (write_count < count && !halted) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_writes(input int first, input int last);
        for (int i = first; i < last; i++) begin
            check_value(got_addr[i], exp_addr[i], $sformatf("write %0d address", i));
            check_value(got_data[i], exp_data[i], $sformatf("write %0d data", i));
        end
    endtask

    task automatic run_tests();
        int fails_before;
        prog_len   = vec[0];
        exp_writes = vec[prog_len + 1];
        for (int i = 0; i < exp_writes; i++) begin
            exp_addr[i] = vec[prog_len + 2 + 2 * i];
            exp_data[i] = vec[prog_len + 3 + 2 * i];
        end
        watchdog_cycles = (prog_len * 3 + exp_writes * 8) * 20;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fails_before = fail_count;
        @(negedge clk);
        check_value(word_t'(psel), 16'd0, "psel after reset");
        check_value(word_t'(penable), 16'd0, "penable after reset");
        check_value(word_t'(halted), 16'd0, "halted after reset");
        load_program();
        repeat (10) @(negedge clk);
        check_value(word_t'(write_count + read_count), 16'd0, "APB transfers before run");
        report_test("1 reset and idle", fails_before);

        fails_before = fail_count;
        @(posedge clk);
        run <= 1'b1;
        wait_for_writes(WB_END);
        compare_writes(0, WB_END);
        report_test("2 register write-back and store", fails_before);

        fails_before = fail_count;
        wait_for_writes(ALU_END);
        compare_writes(WB_END, ALU_END);
        report_test("3 ALU operations", fails_before);

        fails_before = fail_count;
        wait_for_writes(SCRATCH_END);
        compare_writes(ALU_END, SCRATCH_END);
        report_test("4 scratch round trip", fails_before);

        fails_before = fail_count;
        wait_for_writes(exp_writes);
        compare_writes(SCRATCH_END, exp_writes);
        check_value(word_t'(read_count), word_t'(APB_READS), "APB read count");
        report_test("5 APB load with wait states", fails_before);

        fails_before = fail_count;
        check_value(word_t'(halted), 16'd0, "halted before HALT");
        while (!halted) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        check_value(word_t'(halted), 16'd1, "halted after HALT");
        check_value(word_t'(psel), 16'd0, "psel after HALT");
        check_value(word_t'(penable), 16'd0, "penable after HALT");
        check_value(word_t'(write_count), word_t'(exp_writes), "APB write count");
        report_test("6 halt", fails_before);
    endtask

    // APB slave with 0 to 3 random wait states per transfer
    always @(posedge clk) begin : apb_slave
        int waits;
        if (psel && !penable) begin
            waits = $random(seed) & 3;
            wait_left <= waits;
            pready    <= (waits == 0);
            prdata    <= model_mem[paddr[7:0]];
            if (paddr <= 16'h003F) begin
                $display("error at %0t ns: APB transfer to scratch address %h", $time, paddr);
                fail_count++;
            end
            if (!run || halted) begin
                $display("error at %0t ns: APB transfer while the core is not running", $time);
                fail_count++;
            end
        end else if (psel && penable && !pready) begin
            wait_left <= wait_left - 1;
            pready    <= (wait_left == 1);
        end else if (psel && penable && pready) begin
            pready <= 1'b0;
            if (pwrite) begin
                model_mem[paddr[7:0]] = pwdata;
                if (write_count < 64) begin
                    got_addr[write_count] = paddr;
                    got_data[write_count] = pwdata;
                end
                write_count++;
            end else begin
                read_count++;
            end
        end else begin
            pready <= 1'b0;
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the core did not finish within %0d cycles", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        // slave memory word k holds k + 0x100
        for (int k = 0; k < 256; k++) begin
            model_mem[k] = word_t'(k + 'h100);
        end
        $readmemh("tb/vmicro16_input.txt", vec);
        if ($isunknown(vec[0]) || vec[0] == 16'd0 || vec[0] > 16'd64) begin
            $display("no usable program found in tb/vmicro16_input.txt");
            fail_count++;
        end else begin
            run_tests();
        end
        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/vmicro16_input.txt */
// word 0: program length, then the program words, all hex
// then the expected APB write count and one (address data) pair per write, in order
0026
0000 1780 21E0 22E1 25E2 115A 123C 16F0
0B20 2B40 23E3 2BC2 23E4 2B21 23E5 2B84
23E6 3320 23E7 2B85 23E8 2B43 23E9 33C0
23EA 33C1 23EB 1510 26A2 18A2 20EC 15A0
1AA5 22ED 1CBF 24EE F800 21EF
000F
0080 0001  0081 0002  0082 0005
0083 007E  0084 0070  0085 002A
0086 02A0  0087 02FA  0088 002F
0089 FFC3  008A 00B3  008B FFC3
008C 00F0  008D 01A5  008E 01BF
